// ==== alu_stage.sv ====
`timescale 1ns/100ps

module alu_stage #(
    parameter  int ROB_DEPTH = 4,
    localparam int IW        = $clog2(ROB_DEPTH)
) (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              issue,
    input  core_pkg::xlen_t   a,
    input  core_pkg::xlen_t   b,
    input  core_pkg::alu_op_e op,
    input  logic [IW-1:0]     idx,
    output logic              complete,
    output logic [IW-1:0]     complete_idx,
    output core_pkg::xlen_t   result
);
    import core_pkg::*;

    xlen_t alu_out;

    always_comb begin
        case (op)
            ALU_ADD: alu_out = a + b;
            ALU_SUB: alu_out = a - b;
            default: alu_out = b;      // lui passes the immediate
        endcase
    end

    ////////////////////
    // execute register
    ////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            complete <= 1'b0;
        end else begin
            complete <= issue;  // exactly one cycle after issue
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            complete_idx <= idx;
            result       <= alu_out;
        end
    end

endmodule

// ==== build.f ====
core_pkg.sv
fetch_unit.sv
inst_buffer.sv
reg_file.sv
dispatch.sv
alu_stage.sv
rob.sv
core_top.sv
core_tb.sv

// ==== core_pkg.sv ====
package core_pkg;

    ////////////////////
    // widths with a meaning
    ////////////////////

    typedef logic [31:0] xlen_t;     // data word or byte address
    typedef logic [31:0] inst_t;     // one instruction word
    typedef logic [4:0]  reg_idx_t;  // architectural register
    typedef logic [63:0] line_t;     // one memory line, two instructions
    typedef logic [3:0]  mem_tag_t;  // memory response / tag, 0 = nothing

    // memory bus command, loads only
    typedef enum logic [1:0] {
        BUS_NONE = 2'h0,
        BUS_LOAD = 2'h1
    } bus_command_e;

    // core status, sticky once nonzero
    typedef enum logic [1:0] {
        NO_ERROR      = 2'h0,
        HALTED_ON_WFI = 2'h1,
        ILLEGAL_INST  = 2'h2
    } error_status_e;

    typedef enum logic [1:0] {
        ALU_ADD  = 2'h0,
        ALU_SUB  = 2'h1,
        ALU_PASS = 2'h2  // result is operand b
    } alu_op_e;

    ////////////////////
    // decode constants
    ////////////////////

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // addi
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // add, sub
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [6:0] F7_ADD = 7'b0000000;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // the whole wfi word, matched exactly
    localparam inst_t WFI_INST = 32'h1050_0073;

endpackage

// ==== core_tb.sv ====
`timescale 1ns/100ps

module core_tb;
    import core_pkg::*;

    // one expected commit, in program order
    typedef struct packed {
        logic          wr_en;
        reg_idx_t      idx;
        xlen_t         data;
        xlen_t         npc;
        error_status_e err;
    } commit_t;

    logic          clock = 1'b0;
    logic          rst_n;
    mem_tag_t      mem2proc_response;
    line_t         mem2proc_data;
    mem_tag_t      mem2proc_tag;
    bus_command_e  proc2mem_command;
    xlen_t         proc2mem_addr;
    logic [3:0]    completed_insts;
    error_status_e error_status;
    logic          commit_wr_en;
    reg_idx_t      commit_wr_idx;
    xlen_t         commit_wr_data;
    xlen_t         commit_npc;

    inst_t         prog_words [256];   // word index is addr[9:2]
    int            prog_len;
    commit_t       exp_q [$];
    error_status_e final_err;          // status the program ends on
    logic [15:0]   lfsr = 16'd17;
    int            budget = 100;       // watchdog cycles, grows per program
    int            commits = 0;
    int            commit_errors = 0;  // counted by the commit checker
    int            run_errors = 0;     // counted by the main sequence
    int            fetch_errors = 0;   // counted by the memory model

    always #20 clock = ~clock;

    core_top #(.IB_DEPTH(2), .ROB_DEPTH(2)) core_top_i (
        .clock             (clock),
        .rst_n             (rst_n),
        .mem2proc_response (mem2proc_response),
        .mem2proc_data     (mem2proc_data),
        .mem2proc_tag      (mem2proc_tag),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr),
        .completed_insts   (completed_insts),
        .error_status      (error_status),
        .commit_wr_en      (commit_wr_en),
        .commit_wr_idx     (commit_wr_idx),
        .commit_wr_data    (commit_wr_data),
        .commit_npc        (commit_npc)
    );

    ////////////////////
    // helpers
    ////////////////////

    // galois lfsr, one step per bit taken
    function automatic int unsigned take_bits(input int n);
        int unsigned v;
        logic        b;
        v = 0;
        for (int k = 0; k < n; k++) begin
            b    = lfsr[0];
            lfsr = {1'b0, lfsr[15:1]} ^ (b ? 16'hb400 : 16'h0000);
            v    = (v << 1) | 32'(b);
        end
        return v;
    endfunction

    function automatic inst_t enc_addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], 5'(rs1), F3_ADD, 5'(rd), OPC_OP_IMM};
    endfunction

    function automatic inst_t enc_op(input logic [6:0] f7, input int rd, input int rs1,
                                     input int rs2);
        return {f7, 5'(rs2), 5'(rs1), F3_ADD, 5'(rd), OPC_OP};
    endfunction

    function automatic inst_t enc_lui(input int rd, input int imm);
        return {imm[19:0], 5'(rd), OPC_LUI};
    endfunction

    function automatic line_t line_at(input xlen_t a);
        return {prog_words[{a[9:3], 1'b1}], prog_words[{a[9:3], 1'b0}]};  // bit 2 picks upper
    endfunction

    task automatic report_mismatch(input string name, input xlen_t want, input xlen_t got);
        $display("FAIL %0t %s expected %h got %h", $time, name, want, got);
    endtask

    task automatic put(input inst_t w);
        prog_words[prog_len] = w;
        prog_len++;
    endtask

    // reference model, runs the program in order up to wfi or an illegal word
    task automatic build_expected();
        xlen_t   regs [32];
        inst_t   w;
        commit_t c;
        xlen_t   pc;
        logic    done;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        exp_q.delete();
        pc   = '0;
        done = 1'b0;
        while (!done && pc < 32'd1024) begin
            w = prog_words[pc[9:2]];
            c = '{wr_en: 1'b1, idx: w[11:7], data: '0, npc: pc + 32'd4, err: NO_ERROR};
            if (w == WFI_INST) begin
                c.err = HALTED_ON_WFI;
            end else if (w[6:0] == OPC_LUI) begin
                c.data = {w[31:12], 12'h000};
            end else if (w[6:0] == OPC_OP_IMM && w[14:12] == F3_ADD) begin
                c.data = regs[w[19:15]] + {{20{w[31]}}, w[31:20]};
            end else if (w[6:0] == OPC_OP && w[14:12] == F3_ADD && w[31:25] == F7_ADD) begin
                c.data = regs[w[19:15]] + regs[w[24:20]];
            end else if (w[6:0] == OPC_OP && w[14:12] == F3_ADD && w[31:25] == F7_SUB) begin
                c.data = regs[w[19:15]] - regs[w[24:20]];
            end else begin
                c.err = ILLEGAL_INST;
            end
            if (c.err != NO_ERROR || c.idx == '0) begin
                c.wr_en = 1'b0;  // no write for x0, wfi or illegal
            end
            if (c.wr_en) begin
                regs[c.idx] = c.data;
            end
            exp_q.push_back(c);
            final_err = c.err;
            done      = (c.err != NO_ERROR);
            pc        = pc + 32'd4;
        end
    endtask

    task automatic load_program(input int prog);
        for (int i = 0; i < 256; i++) begin
            prog_words[i] = xlen_t'(i * 4) ^ 32'hc0de_0000;  // fill follows the address
        end
        prog_len = 0;
        if (prog == 1) begin
            put(enc_addi(1, 0, 5));          // dependent chain
            put(enc_addi(2, 1, -3));
            put(enc_op(F7_ADD, 3, 1, 2));
            put(enc_op(F7_SUB, 4, 3, 1));
            put(enc_lui(5, 'h12345));
            put(enc_op(F7_ADD, 6, 5, 4));
            put(enc_addi(0, 1, 99));         // dest x0
            put(enc_op(F7_ADD, 7, 0, 3));    // x0 reads zero
            put(enc_op(F7_SUB, 8, 0, 1));
            for (int r = 9; r < 17; r++) begin
                put(enc_addi(r, 0, 100 + r));  // independent burst
            end
            put(enc_op(F7_SUB, 17, 16, 9));
            put(enc_lui(18, 'hfffff));
            put(enc_addi(19, 18, -2048));
            put(WFI_INST);
        end else begin
            put(enc_addi(1, 0, 1));
            put(enc_addi(2, 1, 2));
            put(32'hffff_ffff);              // no such opcode
            put(enc_addi(3, 2, 3));          // must never commit
            put(enc_op(F7_ADD, 4, 1, 2));
        end
        build_expected();
    endtask

    task automatic run_program(input int prog);
        int start;
        int n_exp;
        rst_n = 1'b0;
        load_program(prog);
        n_exp  = exp_q.size();
        start  = commits;
        budget = budget + 200 * prog_len + 100;
        repeat (5) @(negedge clock);
        rst_n = 1'b1;
        while (error_status == NO_ERROR) @(negedge clock);
        repeat (20) @(negedge clock);        // let a fetch in flight drain
        repeat (40) begin
            @(negedge clock);
            assert (proc2mem_command == BUS_NONE) else begin
                report_mismatch("proc2mem_command", 32'(BUS_NONE), 32'(proc2mem_command));
                run_errors++;
            end
            assert (error_status == final_err) else begin
                report_mismatch("error_status", 32'(final_err), 32'(error_status));
                run_errors++;
            end
        end
        assert (commits - start == n_exp) else begin
            report_mismatch("commit count", 32'(n_exp), 32'(commits - start));
            run_errors++;
        end
    endtask

    ////////////////////
    // memory model
    ////////////////////

    initial begin : memory_model
        int unsigned stall_cycles;
        int unsigned delay;
        mem_tag_t    next_tag;
        mem_tag_t    cur_tag;
        xlen_t       req_addr;
        xlen_t       fetch_addr;                    // where the next load should point
        mem2proc_response = '0;
        mem2proc_tag      = '0;
        mem2proc_data     = '0;
        next_tag          = 4'd1;
        fetch_addr        = '0;
        forever begin
            @(negedge clock);
            mem2proc_response = '0;
            mem2proc_tag      = '0;
            if (!rst_n) begin
                fetch_addr = '0;                    // program restarts at 0
            end
            if (rst_n && proc2mem_command == BUS_LOAD) begin
                stall_cycles = take_bits(2);            // 0..3 wait cycles
                repeat (stall_cycles) @(negedge clock);
                req_addr          = proc2mem_addr;
                assert (req_addr == fetch_addr) else begin
                    report_mismatch("proc2mem_addr", fetch_addr, req_addr);
                    fetch_errors++;
                end
                fetch_addr        = fetch_addr + 32'd4;
                cur_tag           = next_tag;
                mem2proc_response = cur_tag;            // accept
                next_tag          = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                delay             = 1 + take_bits(3) % 7;
                @(negedge clock);
                mem2proc_response = '0;
                repeat (delay - 1) @(negedge clock);
                mem2proc_tag  = cur_tag;                // line comes back
                mem2proc_data = line_at(req_addr);
            end
        end
    end

    ////////////////////
    // commit checker
    ////////////////////

    always @(negedge clock) begin : check_commit
        commit_t want;
        if (rst_n && completed_insts != 4'd0) begin
            commits++;
            assert (exp_q.size() != 0) else begin
                $display("%0t: a commit came after the program should have stopped", $time);
                commit_errors++;
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                assert (completed_insts == 4'd1) else begin
                    report_mismatch("completed_insts", 32'd1, 32'(completed_insts));
                    commit_errors++;
                end
                assert (commit_wr_en == want.wr_en) else begin
                    report_mismatch("commit_wr_en", 32'(want.wr_en), 32'(commit_wr_en));
                    commit_errors++;
                end
                assert (commit_npc == want.npc) else begin   // catches skips and repeats
                    report_mismatch("commit_npc", want.npc, commit_npc);
                    commit_errors++;
                end
                assert (error_status == want.err) else begin
                    report_mismatch("error_status", 32'(want.err), 32'(error_status));
                    commit_errors++;
                end
                if (want.wr_en) begin
                    assert (commit_wr_idx == want.idx) else begin
                        report_mismatch("commit_wr_idx", 32'(want.idx), 32'(commit_wr_idx));
                        commit_errors++;
                    end
                    assert (commit_wr_data == want.data) else begin
                        report_mismatch("commit_wr_data", want.data, commit_wr_data);
                        commit_errors++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < budget) begin
            @(posedge clock);
            cycles++;
        end
        $display("watchdog: the core did not halt within %0d cycles", cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        run_program(1);   // ends on wfi
        run_program(2);   // ends on an illegal word
        $display("commits %0d, commit errors %0d, run errors %0d, fetch errors %0d",
                 commits, commit_errors, run_errors, fetch_errors);
        if (commit_errors + run_errors + fetch_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== core_top.sv ====
`timescale 1ns/100ps

module core_top #(
    parameter  int IB_DEPTH  = 4,
    parameter  int ROB_DEPTH = 4,
    localparam int IW        = $clog2(ROB_DEPTH)
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  core_pkg::mem_tag_t      mem2proc_response,
    input  core_pkg::line_t         mem2proc_data,
    input  core_pkg::mem_tag_t      mem2proc_tag,
    output core_pkg::bus_command_e  proc2mem_command,
    output core_pkg::xlen_t         proc2mem_addr,
    output logic [3:0]              completed_insts,
    output core_pkg::error_status_e error_status,
    output logic                    commit_wr_en,
    output core_pkg::reg_idx_t      commit_wr_idx,
    output core_pkg::xlen_t         commit_wr_data,
    output core_pkg::xlen_t         commit_npc
);
    import core_pkg::*;

    ////////////////////
    // wires
    ////////////////////

    logic          ib_full;
    logic          ib_empty;
    logic          ib_pop;
    logic          fetch_push;
    inst_t         fetch_inst;
    xlen_t         fetch_npc;
    inst_t         ib_head_inst;
    xlen_t         ib_head_npc;
    reg_idx_t      rs1;
    reg_idx_t      rs2;
    xlen_t         rs1_data;
    xlen_t         rs2_data;
    logic          rob_full;
    logic [31:0]   pending;
    logic          halt;
    logic [IW-1:0] alloc_idx;
    logic          alloc;
    reg_idx_t      alloc_dest;
    logic          alloc_wr_en;
    xlen_t         alloc_npc;
    error_status_e alloc_error;
    logic          issue;
    xlen_t         issue_a;
    xlen_t         issue_b;
    alu_op_e       issue_op;
    logic [IW-1:0] issue_idx;
    logic          complete;
    logic [IW-1:0] complete_idx;
    xlen_t         result;
    logic          rf_wr_en;
    reg_idx_t      rf_wr_idx;
    xlen_t         rf_wr_data;

    fetch_unit fetch_unit_i (
        .clock    (clock),
        .rst_n    (rst_n),
        .full     (ib_full),
        .halt     (halt),
        .response (mem2proc_response),
        .tag      (mem2proc_tag),
        .data     (mem2proc_data),
        .command  (proc2mem_command),
        .addr     (proc2mem_addr),
        .push     (fetch_push),
        .inst     (fetch_inst),
        .npc      (fetch_npc)
    );

    // the landing line holds its slot until the count catches up
    inst_buffer #(.IB_DEPTH(IB_DEPTH)) inst_buffer_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .push      (fetch_push),
        .inst      (fetch_inst),
        .npc       (fetch_npc),
        .pop       (ib_pop),
        .reserve   (fetch_push),
        .full      (ib_full),
        .empty     (ib_empty),
        .head_inst (ib_head_inst),
        .head_npc  (ib_head_npc)
    );

    reg_file reg_file_i (
        .clock    (clock),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (rf_wr_en),
        .wr_idx   (rf_wr_idx),
        .wr_data  (rf_wr_data)
    );

    dispatch #(.ROB_DEPTH(ROB_DEPTH)) dispatch_i (
        .empty       (ib_empty),
        .head_inst   (ib_head_inst),
        .head_npc    (ib_head_npc),
        .rob_full    (rob_full),
        .pending     (pending),
        .halt        (halt),
        .alloc_idx   (alloc_idx),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .pop         (ib_pop),
        .rs1         (rs1),
        .rs2         (rs2),
        .alloc       (alloc),
        .alloc_dest  (alloc_dest),
        .alloc_wr_en (alloc_wr_en),
        .alloc_npc   (alloc_npc),
        .alloc_error (alloc_error),
        .issue       (issue),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_op    (issue_op),
        .issue_idx   (issue_idx)
    );

    alu_stage #(.ROB_DEPTH(ROB_DEPTH)) alu_stage_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .issue        (issue),
        .a            (issue_a),
        .b            (issue_b),
        .op           (issue_op),
        .idx          (issue_idx),
        .complete     (complete),
        .complete_idx (complete_idx),
        .result       (result)
    );

    rob #(.ROB_DEPTH(ROB_DEPTH)) rob_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .alloc           (alloc),
        .alloc_dest      (alloc_dest),
        .alloc_wr_en     (alloc_wr_en),
        .alloc_npc       (alloc_npc),
        .alloc_error     (alloc_error),
        .complete        (complete),
        .complete_idx    (complete_idx),
        .result          (result),
        .full            (rob_full),
        .alloc_idx       (alloc_idx),
        .pending         (pending),
        .halt            (halt),
        .rf_wr_en        (rf_wr_en),
        .rf_wr_idx       (rf_wr_idx),
        .rf_wr_data      (rf_wr_data),
        .completed_insts (completed_insts),
        .error_status    (error_status),
        .commit_wr_en    (commit_wr_en),
        .commit_wr_idx   (commit_wr_idx),
        .commit_wr_data  (commit_wr_data),
        .commit_npc      (commit_npc)
    );

endmodule

// ==== dispatch.sv ====
`timescale 1ns/100ps

module dispatch #(
    parameter  int ROB_DEPTH = 4,
    localparam int IW        = $clog2(ROB_DEPTH)
) (
    input  logic                    empty,
    input  core_pkg::inst_t         head_inst,
    input  core_pkg::xlen_t         head_npc,
    input  logic                    rob_full,
    input  logic [31:0]             pending,     // dest of some live rob entry
    input  logic                    halt,
    input  logic [IW-1:0]           alloc_idx,
    input  core_pkg::xlen_t         rs1_data,
    input  core_pkg::xlen_t         rs2_data,
    output logic                    pop,
    output core_pkg::reg_idx_t      rs1,
    output core_pkg::reg_idx_t      rs2,
    output logic                    alloc,
    output core_pkg::reg_idx_t      alloc_dest,
    output logic                    alloc_wr_en,
    output core_pkg::xlen_t         alloc_npc,
    output core_pkg::error_status_e alloc_error,
    output logic                    issue,
    output core_pkg::xlen_t         issue_a,
    output core_pkg::xlen_t         issue_b,
    output core_pkg::alu_op_e       issue_op,
    output logic [IW-1:0]           issue_idx
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;
    xlen_t      imm_i;
    xlen_t      imm_u;
    logic       is_addi;
    logic       is_add;
    logic       is_sub;
    logic       is_lui;
    logic       is_wfi;
    logic       legal;      // goes to the alu
    logic       use_rs1;
    logic       use_rs2;
    logic       stall;
    logic       go;

    ////////////////////
    // decode
    ////////////////////

    assign opcode = head_inst[6:0];
    assign rd     = head_inst[11:7];
    assign funct3 = head_inst[14:12];
    assign rs1    = head_inst[19:15];
    assign rs2    = head_inst[24:20];
    assign funct7 = head_inst[31:25];

    assign imm_i = {{20{head_inst[31]}}, head_inst[31:20]};  // sign extended
    assign imm_u = {head_inst[31:12], 12'b0};

    assign is_addi = (opcode == OPC_OP_IMM) && (funct3 == F3_ADD);
    assign is_add  = (opcode == OPC_OP) && (funct3 == F3_ADD) && (funct7 == F7_ADD);
    assign is_sub  = (opcode == OPC_OP) && (funct3 == F3_ADD) && (funct7 == F7_SUB);
    assign is_lui  = (opcode == OPC_LUI);
    assign is_wfi  = (head_inst == WFI_INST);
    assign legal   = is_addi || is_add || is_sub || is_lui;

    assign use_rs1 = is_addi || is_add || is_sub;  // lui has no sources
    assign use_rs2 = is_add || is_sub;

    ////////////////////
    // issue rule
    ////////////////////

    // a pending source means its producer has not committed yet
    assign stall = (use_rs1 && pending[rs1]) || (use_rs2 && pending[rs2]);
    assign go    = !empty && !rob_full && !halt && !stall;

    assign pop   = go;
    assign alloc = go;
    assign issue = go && legal;  // wfi and illegal only take a rob entry

    assign alloc_dest  = rd;
    assign alloc_wr_en = legal && (rd != '0);   // x0 never written
    assign alloc_npc   = head_npc;
    assign alloc_error = legal ? NO_ERROR : (is_wfi ? HALTED_ON_WFI : ILLEGAL_INST);

    assign issue_a   = rs1_data;
    assign issue_b   = is_addi ? imm_i : (is_lui ? imm_u : rs2_data);
    assign issue_op  = is_sub ? ALU_SUB : (is_lui ? ALU_PASS : ALU_ADD);
    assign issue_idx = alloc_idx;  // result goes back to its own entry

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   full,      // buffer has no slot to spare
    input  logic                   halt,      // wfi or illegal has committed
    input  core_pkg::mem_tag_t     response,
    input  core_pkg::mem_tag_t     tag,
    input  core_pkg::line_t        data,
    output core_pkg::bus_command_e command,
    output core_pkg::xlen_t        addr,
    output logic                   push,
    output core_pkg::inst_t        inst,
    output core_pkg::xlen_t        npc
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,    // load on the bus, waiting for a nonzero response
        WAIT_DATA   // accepted, waiting for our tag to come back
    } fetch_state_e;

    fetch_state_e state;
    fetch_state_e state_nxt;
    xlen_t        pc;         // address of the instruction in flight
    mem_tag_t     saved_tag;
    logic         accept;
    logic         arrive;

    assign accept = (state == REQUEST) && (response != '0);
    assign arrive = (state == WAIT_DATA) && (tag == saved_tag);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (!full && !halt) begin
                    state_nxt = REQUEST;
                end
            end
            REQUEST: begin
                if (accept) begin
                    state_nxt = WAIT_DATA;
                end
            end
            WAIT_DATA: begin
                // back to back when there is room, full already counts this line
                if (arrive) begin
                    state_nxt = (!full && !halt) ? REQUEST : IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            pc        <= '0;
            saved_tag <= '0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                saved_tag <= response;  // response value is the tag of this load
            end
            if (arrive) begin
                pc <= pc + 32'd4;
            end
        end
    end

    assign command = (state == REQUEST) ? BUS_LOAD : BUS_NONE;
    assign addr    = pc;                                // held until accepted
    assign push    = arrive;
    assign inst    = pc[2] ? data[63:32] : data[31:0];  // pick half of the line
    assign npc     = pc + 32'd4;

    // memory may stall the request, the address must not move meanwhile
    a_addr_held : assert property (@(posedge clock) disable iff (!rst_n)
        (command == BUS_LOAD && response == '0) |=> (command == BUS_LOAD && $stable(addr)));

endmodule

// ==== inst_buffer.sv ====
`timescale 1ns/100ps

module inst_buffer #(
    parameter  int IB_DEPTH = 4,
    localparam int PW       = $clog2(IB_DEPTH)
) (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            push,
    input  core_pkg::inst_t inst,
    input  core_pkg::xlen_t npc,
    input  logic            pop,
    input  logic            reserve,    // line landing from fetch, not yet counted
    output logic            full,
    output logic            empty,
    output core_pkg::inst_t head_inst,
    output core_pkg::xlen_t head_npc
);
    import core_pkg::*;

    inst_t         inst_q [IB_DEPTH];
    xlen_t         npc_q  [IB_DEPTH];
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [PW:0]   count;      // entries really held
    logic [PW:0]   claimed;    // held plus reserved

    assign claimed   = count + (PW+1)'(reserve);
    assign full      = claimed >= (PW+1)'(IB_DEPTH);
    assign empty     = (count == '0);
    assign head_inst = inst_q[rd_ptr];
    assign head_npc  = npc_q[rd_ptr];

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge clock) begin
        if (push) begin
            inst_q[wr_ptr] <= inst;
            npc_q[wr_ptr]  <= npc;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PW+1)'(push) - (PW+1)'(pop);
        end
    end

    // fetch only starts a load with a slot free
    a_no_overflow : assert property (@(posedge clock) disable iff (!rst_n)
        push |-> (count < (PW+1)'(IB_DEPTH)));

    a_no_underflow : assert property (@(posedge clock) disable iff (!rst_n)
        pop |-> !empty);

endmodule

// ==== reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
    input  logic               clock,
    input  logic               rst_n,
    input  core_pkg::reg_idx_t rs1,
    input  core_pkg::reg_idx_t rs2,
    output core_pkg::xlen_t    rs1_data,
    output core_pkg::xlen_t    rs2_data,
    input  logic               wr_en,      // from commit
    input  core_pkg::reg_idx_t wr_idx,
    input  core_pkg::xlen_t    wr_data
);
    import core_pkg::*;

    xlen_t regs [32];

    // x0 reads zero whatever the array holds
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // every program starts from all-zero registers
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

// ==== rob.sv ====
`timescale 1ns/100ps

module rob #(
    parameter  int ROB_DEPTH = 4,
    localparam int IW        = $clog2(ROB_DEPTH)
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    alloc,
    input  core_pkg::reg_idx_t      alloc_dest,
    input  logic                    alloc_wr_en,
    input  core_pkg::xlen_t         alloc_npc,
    input  core_pkg::error_status_e alloc_error,
    input  logic                    complete,
    input  logic [IW-1:0]           complete_idx,
    input  core_pkg::xlen_t         result,
    output logic                    full,
    output logic [IW-1:0]           alloc_idx,
    output logic [31:0]             pending,
    output logic                    halt,
    output logic                    rf_wr_en,
    output core_pkg::reg_idx_t      rf_wr_idx,
    output core_pkg::xlen_t         rf_wr_data,
    output logic [3:0]              completed_insts,
    output core_pkg::error_status_e error_status,
    output logic                    commit_wr_en,
    output core_pkg::reg_idx_t      commit_wr_idx,
    output core_pkg::xlen_t         commit_wr_data,
    output core_pkg::xlen_t         commit_npc
);
    import core_pkg::*;

    typedef logic [IW-1:0] rob_idx_t;

    logic [ROB_DEPTH-1:0] ent_valid;
    logic [ROB_DEPTH-1:0] ent_done;
    logic [ROB_DEPTH-1:0] ent_wr_en;
    reg_idx_t             ent_dest  [ROB_DEPTH];
    xlen_t                ent_value [ROB_DEPTH];
    xlen_t                ent_npc   [ROB_DEPTH];
    error_status_e        ent_error [ROB_DEPTH];
    rob_idx_t             head;      // oldest entry
    rob_idx_t             tail;      // next free entry
    logic [IW:0]          count;
    logic                 commit;

    assign full      = (count == (IW+1)'(ROB_DEPTH));
    assign alloc_idx = tail;
    assign halt      = (error_status != NO_ERROR);

    // nothing retires past a halt
    assign commit     = ent_valid[head] && ent_done[head] && !halt;
    assign rf_wr_en   = commit && ent_wr_en[head];
    assign rf_wr_idx  = ent_dest[head];
    assign rf_wr_data = ent_value[head];

    always_comb begin
        pending = '0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (ent_valid[i] && ent_wr_en[i]) begin
                pending[ent_dest[i]] = 1'b1;
            end
        end
    end

    ////////////////////
    // control and status
    ////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ent_valid       <= '0;
            ent_done        <= '0;
            head            <= '0;
            tail            <= '0;
            count           <= '0;
            completed_insts <= '0;
            commit_wr_en    <= 1'b0;
            error_status    <= NO_ERROR;
        end else begin
            if (alloc) begin
                ent_valid[tail] <= 1'b1;
                ent_done[tail]  <= (alloc_error != NO_ERROR);  // no alu work for these
                tail            <= tail + 1'b1;
            end
            if (complete) begin
                ent_done[complete_idx] <= 1'b1;
            end
            if (commit) begin
                ent_valid[head] <= 1'b0;
                head            <= head + 1'b1;
                if (ent_error[head] != NO_ERROR) begin
                    error_status <= ent_error[head];  // raises halt
                end
            end
            count           <= count + (IW+1)'(alloc) - (IW+1)'(commit);
            completed_insts <= {3'b000, commit};
            commit_wr_en    <= rf_wr_en;
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            ent_dest[tail]  <= alloc_dest;
            ent_wr_en[tail] <= alloc_wr_en;
            ent_npc[tail]   <= alloc_npc;
            ent_error[tail] <= alloc_error;
            ent_value[tail] <= '0;
        end
        if (complete) begin
            ent_value[complete_idx] <= result;
        end
        if (commit) begin
            commit_wr_idx  <= ent_dest[head];
            commit_wr_data <= ent_value[head];
            commit_npc     <= ent_npc[head];
        end
    end

    a_no_alloc_full : assert property (@(posedge clock) disable iff (!rst_n)
        alloc |-> !full);

    // alu result must land in a live entry still waiting for it
    a_complete_live : assert property (@(posedge clock) disable iff (!rst_n)
        complete |-> (ent_valid[complete_idx] && !ent_done[complete_idx]));

endmodule

// ==== run.sh ====
#!/bin/bash
# compile with verilator, run the testbench, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f build.f --top-module core_tb -o core_tb_sim \
    && ./obj_dir/core_tb_sim > sim.log 2>&1 \
    || echo "ERRORS FOUND" >> sim.log
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1 || exit 0
